/* project.f */
+incdir+.
qbus_pkg.sv
req_sync.sv
irq_ctrl.sv
qbus_timer.sv
dma_arbiter.sv
qbus_ctl_top.sv
tb_qbus_ctl.sv

/* Bender.yml */
package:
  name: qbus_ctl

sources:
  - qbus_pkg.sv
  - req_sync.sv
  - irq_ctrl.sv
  - qbus_timer.sv
  - dma_arbiter.sv
  - qbus_ctl_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_qbus_ctl.sv

/* tb_qbus_tasks.svh */
//************************************************************
// Q-bus control unit directed tests
// stimulus tasks, reference priority rule, typed compares
//************************************************************
`ifndef TB_QBUS_TASKS_SVH
`define TB_QBUS_TASKS_SVH

task automatic check_irq(input string t, input qbus_pkg::irq_t exp, input qbus_pkg::irq_t act);
begin
   if (exp !== act)
   begin
      $display("[ERROR] %s: expected %0h, actual %0h", t, exp, act);
      stop_run("interrupt result mismatch");
   end
end
endtask

task automatic check_bit(input string t, input logic exp, input logic act);
begin
   if (exp !== act)
   begin
      $display("[ERROR] %s: expected %0b, actual %0b", t, exp, act);
      stop_run("flag mismatch");
   end
end
endtask

task automatic check_count(input string t, input int exp, input int act);
begin
   if (exp != act)
   begin
      $display("[ERROR] %s: expected %0d, actual %0d", t, exp, act);
      stop_run("edge count mismatch");
   end
end
endtask

task automatic step(input int n);
begin
   repeat (n) @(negedge pin_clk);                  // drive and check point
end
endtask

task automatic idle_gap();
begin
   step($urandom_range(4, 1));
end
endtask

task automatic pulse_ctl(input qbus_pkg::ctl_t c);
begin
   ctl = c;
   step(1);
   ctl = '0;
end
endtask

// fixed priority rule, evnt and virq masked by pri
function automatic qbus_pkg::irq_t expected_irq(input qbus_pkg::irq_pins_t p,
                                                input qbus_pkg::psw_t s);
   qbus_pkg::irq_t r;
begin
   r.pending = 1'b1;
   if (p.rfrq)                r.vector = qbus_pkg::vec_rfrq;
   else if (s.trace)          r.vector = qbus_pkg::vec_trace;
   else if (p.aclo)           r.vector = qbus_pkg::vec_aclo;
   else if (p.halt)           r.vector = qbus_pkg::vec_halt;
   else if (p.evnt && !s.pri) r.vector = qbus_pkg::vec_evnt;
   else if (p.virq && !s.pri) r.vector = qbus_pkg::vec_virq;
   else
   begin
      r.vector  = qbus_pkg::vec_none;
      r.pending = 1'b0;
   end
   return r;
end
endfunction

// drop every sticky latch and the refresh strobe
task automatic clear_all();
   qbus_pkg::ctl_t c;
begin
   c = '0;
   c.clr_aclo = 1'b1;
   c.clr_evnt = 1'b1;
   c.set_ref  = 1'b1;
   pulse_ctl(c);
   c = '0;
   c.clr_ref = 1'b1;
   pulse_ctl(c);
   step(3);
end
endtask

task automatic test_reset();
   qbus_pkg::irq_t idle;
begin
   idle = '{pending: 1'b0, vector: qbus_pkg::vec_none};
   step(1);
   check_irq("reset", idle, irq);
   check_bit("reset timeout", 1'b0, timeout);
   check_bit("reset dref", 1'b0, dref);
   check_bit("reset dmgo", 1'b0, dmgo);
end
endtask

task automatic test_priority();
   // aclo evnt rfrq halt virq
   logic [4:0] pats [8] = '{5'b00001, 5'b01000, 5'b01001, 5'b00010,
                            5'b00011, 5'b10011, 5'b11111, 5'b00100};
   int         order [8];
   int         j;
   int         tmp;
   qbus_pkg::irq_pins_t p;
begin
   for (int pri = 0; pri < 2; pri++)
   begin
      for (int i = 0; i < 8; i++)
         order[i] = i;
      for (int i = 7; i > 0; i--)                  // shuffle case order
      begin
         j        = $urandom_range(i, 0);
         tmp      = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      psw.pri = pri[0];
      for (int i = 0; i < 8; i++)
      begin
         p        = qbus_pkg::irq_pins_t'(pats[order[i]]);
         irq_pins = p;
         step(3);
         check_irq("priority", expected_irq(p, psw), irq);
         irq_pins = '0;
         clear_all();
         check_irq("priority idle", expected_irq('0, psw), irq);
      end
   end
   psw.trace = 1'b1;                               // trace over aclo
   irq_pins  = qbus_pkg::irq_pins_t'(5'b10000);
   step(3);
   check_irq("priority trace", expected_irq(irq_pins, psw), irq);
   irq_pins = '0;
   psw      = '0;
   clear_all();
end
endtask

task automatic test_latches();
   qbus_pkg::ctl_t c;
   qbus_pkg::irq_t e;
begin
   e = '{pending: 1'b1, vector: qbus_pkg::vec_aclo};
   irq_pins.aclo = 1'b1;                           // one cycle pulse
   step(1);
   irq_pins.aclo = 1'b0;
   step(6);
   check_irq("aclo latch", e, irq);
   c = '0;
   c.clr_aclo = 1'b1;
   pulse_ctl(c);
   step(2);
   check_irq("aclo clear", expected_irq('0, psw), irq);
   e.vector = qbus_pkg::vec_evnt;
   irq_pins.evnt = 1'b1;
   step(1);
   irq_pins.evnt = 1'b0;
   step(6);
   check_irq("evnt latch", e, irq);
   c = '0;
   c.clr_evnt = 1'b1;
   pulse_ctl(c);
   step(2);
   check_irq("evnt clear", expected_irq('0, psw), irq);
   e.vector = qbus_pkg::vec_rfrq;
   irq_pins.rfrq = 1'b1;
   step(1);
   irq_pins.rfrq = 1'b0;
   step(6);
   check_irq("rfrq latch", e, irq);
   check_bit("dref idle", 1'b0, dref);
   c = '0;
   c.set_ref = 1'b1;
   pulse_ctl(c);
   step(1);
   check_irq("set_ref clears rfrq", expected_irq('0, psw), irq);
   check_bit("dref set", 1'b1, dref);
   c = '0;
   c.clr_ref = 1'b1;
   pulse_ctl(c);
   check_bit("dref clear", 1'b0, dref);
end
endtask

task automatic test_timeout();
   int n;
   qbus_pkg::ctl_t c;
begin
   n       = 0;
   cyc.din = 1'b1;                                 // first edge is edge 1
   while (!timeout && n < 100)
   begin
      @(posedge pin_clk);
      n++;
      @(negedge pin_clk);
   end
   check_count("timeout edge", 65, n);
   cyc.din = 1'b0;
   step(3);
   check_bit("timeout sticky", 1'b1, timeout);
   c = '0;
   c.clr_timeout = 1'b1;
   pulse_ctl(c);
   check_bit("timeout clear", 1'b0, timeout);
   cyc.din = 1'b1;                                 // slave replies in time
   step(30);
   bus_pins.rply = 1'b1;
   for (int i = 0; i < 70; i++)
   begin
      step(1);
      check_bit("timeout with rply", 1'b0, timeout);
   end
   cyc.din       = 1'b0;
   bus_pins.rply = 1'b0;
   step(2);
end
endtask

task automatic test_dma();
   int n;
begin
   n            = 0;
   bus_pins.dmr = 1'b1;                            // seen at edge 1
   while (!dmgo && n < 20)
   begin
      @(posedge pin_clk);
      n++;
      @(negedge pin_clk);
   end
   check_count("dmr to dmgo", 4, n);
   n             = 0;
   bus_pins.sack = 1'b1;
   while (dmgo && n < 20)
   begin
      @(posedge pin_clk);
      n++;
      @(negedge pin_clk);
   end
   check_count("sack drops dmgo", 3, n);
   bus_pins = '0;
   step(4);
   cyc.sync     = 1'b1;                            // cpu owns the bus
   bus_pins.dmr = 1'b1;
   for (int i = 0; i < 10; i++)
   begin
      step(1);
      check_bit("dmgo during sync", 1'b0, dmgo);
   end
   bus_pins.dmr = 1'b0;
   step(4);
   cyc.sync = 1'b0;
   step(2);
   check_bit("dmgo after sync", 1'b0, dmgo);
end
endtask

`endif

/* tb_qbus_ctl.sv */
//************************************************************
// Q-bus control unit testbench
// clock, reset, watchdog and directed test sequence
//************************************************************
`timescale 1ns/1ps

module tb_qbus_ctl;

   localparam int clk_period  = 4;                 // ns
   localparam int reset_len   = 16;                // cycles of dclo
   localparam int test_cycles = 400;               // summed test lengths
   localparam int margin      = 200;               // slack for idle gaps

   logic                pin_clk;
   logic                dclo;
   qbus_pkg::irq_pins_t irq_pins;                  // request pins
   qbus_pkg::bus_pins_t bus_pins;                  // rply/sack/dmr
   qbus_pkg::cyc_t      cyc;                       // cpu cycle strobes
   qbus_pkg::ctl_t      ctl;                       // clear/set strobes
   qbus_pkg::psw_t      psw;                       // pri and trace
   qbus_pkg::irq_t      irq;
   logic                timeout;
   logic                dref;
   logic                dmgo;

   qbus_ctl_top DUT
   (
      .pin_clk    (pin_clk),
      .dclo       (dclo),
      .irq_pins_i (irq_pins),
      .bus_pins_i (bus_pins),
      .cyc_i      (cyc),
      .ctl_i      (ctl),
      .psw_i      (psw),
      .irq_o      (irq),
      .timeout_o  (timeout),
      .dref_o     (dref),
      .dmgo_o     (dmgo)
   );

   // report a failure and end the run
   task automatic stop_run(input string why);
   begin
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1);
   end
   endtask

   `include "tb_qbus_tasks.svh"

   always #(clk_period/2) pin_clk = ~pin_clk;      // 4 ns clock

   // watchdog
   initial
   begin
      #((test_cycles + margin) * clk_period);
      stop_run("watchdog expired, tests did not finish in time");
   end

   initial
   begin
      void'($urandom(25606));                      // one seed for the run
      pin_clk  = 1'b0;
      dclo     = 1'b1;
      irq_pins = '0;
      bus_pins = '0;
      cyc      = '0;
      ctl      = '0;
      psw      = '0;
      step(reset_len);
      dclo = 1'b0;                                 // released on falling edge
      test_reset();
      idle_gap();
      test_priority();
      idle_gap();
      test_latches();
      idle_gap();
      test_timeout();
      idle_gap();
      test_dma();
      $display("Done: no errors");
      $finish;
   end

endmodule

/* qbus_ctl_top.sv */
//************************************************************
// Q-bus control unit top level
// pin samplers, interrupt controller, watchdog and arbiter
//************************************************************
`timescale 1ns/1ps

module qbus_ctl_top
(
   input  logic                pin_clk,            // processor clock
   input  logic                dclo,               // processor reset
   input  qbus_pkg::irq_pins_t irq_pins_i,         // request pins
   input  qbus_pkg::bus_pins_t bus_pins_i,         // rply/sack/dmr pins
   input  qbus_pkg::cyc_t      cyc_i,              // cpu bus cycle strobes
   input  qbus_pkg::ctl_t      ctl_i,              // clear/set strobes
   input  qbus_pkg::psw_t      psw_i,              // priority and trace
   output qbus_pkg::irq_t      irq_o,              // interrupt result
   output logic                timeout_o,          // bus timeout flag
   output logic                dref_o,             // dram refresh
   output logic                dmgo_o              // dma grant
);

   qbus_pkg::irq_pins_t irq_smp;                   // sampled request pins
   qbus_pkg::irq_pins_t irq_rise;                  // request rise flags
   qbus_pkg::bus_pins_t bus_smp;                   // sampled bus pins

   req_sync #(.payload_t(qbus_pkg::irq_pins_t)) u_irq_sync
   (
      .pin_clk   (pin_clk),
      .dclo      (dclo),
      .pins_i    (irq_pins_i),
      .sampled_o (irq_smp),
      .rise_o    (irq_rise)
   );

   req_sync #(.payload_t(qbus_pkg::bus_pins_t)) u_bus_sync
   (
      .pin_clk   (pin_clk),
      .dclo      (dclo),
      .pins_i    (bus_pins_i),
      .sampled_o (bus_smp),
      .rise_o    ()                                // bus edges not needed
   );

   irq_ctrl u_irq_ctrl
   (
      .pin_clk (pin_clk),
      .dclo    (dclo),
      .pins_i  (irq_smp),
      .rise_i  (irq_rise),
      .psw_i   (psw_i),
      .ctl_i   (ctl_i),
      .irq_o   (irq_o),
      .dref_o  (dref_o)
   );

   qbus_timer u_qbus_timer
   (
      .pin_clk   (pin_clk),
      .dclo      (dclo),
      .cyc_i     (cyc_i),
      .rply_i    (bus_smp.rply),
      .clr_i     (ctl_i.clr_timeout),
      .timeout_o (timeout_o)
   );

   dma_arbiter u_dma_arbiter
   (
      .pin_clk (pin_clk),
      .dclo    (dclo),
      .dmr_i   (bus_smp.dmr),
      .sack_i  (bus_smp.sack),
      .sync_i  (cyc_i.sync),                       // raw cpu sync blocks grant
      .dmgo_o  (dmgo_o)
   );

endmodule

/* dma_arbiter.sv */
//************************************************************
// DMA bus arbiter
// dmr/sack/dmgo handshake against processor sync cycles
//************************************************************
`timescale 1ns/1ps

module dma_arbiter
(
   input  logic pin_clk,                           // processor clock
   input  logic dclo,                              // processor reset
   input  logic dmr_i,                             // sampled bus request
   input  logic sack_i,                            // sampled acknowledge
   input  logic sync_i,                            // processor address strobe
   output logic dmgo_o                             // bus granted
);

   logic dreq_q;                                   // tracked request
   logic pgnt_q;                                   // pre-grant stage
   logic dmgo_q;                                   // grant stage

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
      begin
         dreq_q <= 1'b0;
         pgnt_q <= 1'b0;
         dmgo_q <= 1'b0;
      end
      else
      begin
         dreq_q <= sack_i | dmr_i;                 // hold while master owns bus
         pgnt_q <= dreq_q & ~sack_i;               // sack withdraws grant
         dmgo_q <= pgnt_q & ~sync_i;               // no grant over cpu cycle
      end
   end

   assign dmgo_o = dmgo_q;

   a_no_grant_in_sync : assert property (@(posedge pin_clk) disable iff (dclo)
      $rose(sync_i) |=> !(dmgo_o && sync_i));

endmodule

/* qbus_timer.sv */
//************************************************************
// Q-bus transaction watchdog
// counts data strobe cycles, flags a missing reply as timeout
//************************************************************
`timescale 1ns/1ps

module qbus_timer
(
   input  logic           pin_clk,                 // processor clock
   input  logic           dclo,                    // processor reset
   input  qbus_pkg::cyc_t cyc_i,                   // current bus cycle
   input  logic           rply_i,                  // sampled reply
   input  logic           clr_i,                   // drop timeout flag
   output logic           timeout_o                // sticky bus timeout
);

   logic [qbus_pkg::qt_width-1:0] qt_cnt;          // watchdog counter
   logic                          qt_req;          // one cycle expiry request
   logic                          to_q;            // timeout flag
   logic                          strobe;          // din or dout active

   assign strobe = cyc_i.din | cyc_i.dout;

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
      begin
         qt_cnt <= '0;
         qt_req <= 1'b0;
      end
      else if (strobe)
      begin
         qt_cnt <= qt_cnt + 1'b1;
         qt_req <= &qt_cnt & ~rply_i;              // all ones, still no reply
      end
      else
      begin
         qt_cnt <= '0;                             // rest between cycles
         qt_req <= 1'b0;
      end
   end

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
         to_q <= 1'b0;
      else if (clr_i)
         to_q <= 1'b0;                             // clear beats expiry
      else if (qt_req)
         to_q <= 1'b1;
   end

   assign timeout_o = to_q;

   // expiry needs a strobe that ran through the whole count
   a_req_needs_strobe : assert property (@(posedge pin_clk) disable iff (dclo)
      $rose(qt_req) |-> $past(strobe) && $past(strobe, 1 << qbus_pkg::qt_width));

endmodule

/* irq_ctrl.sv */
//************************************************************
// Interrupt and service request controller
// sticky aclo/evnt/rfrq latches, dram refresh strobe and the
// registered priority encoder for the interrupt vector
//************************************************************
`timescale 1ns/1ps

module irq_ctrl
(
   input  logic                pin_clk,            // processor clock
   input  logic                dclo,               // processor reset
   input  qbus_pkg::irq_pins_t pins_i,             // sampled request pins
   input  qbus_pkg::irq_pins_t rise_i,             // rising request flags
   input  qbus_pkg::psw_t      psw_i,              // priority and trace bits
   input  qbus_pkg::ctl_t      ctl_i,              // clear/set strobes
   output qbus_pkg::irq_t      irq_o,              // pending flag and vector
   output logic                dref_o              // dram refresh strobe
);

   logic           aclo_q;                         // power fail latch
   logic           evnt_q;                         // timer event latch
   logic           rfrq_q;                         // refresh request latch
   logic           halt_q;                         // halt level, aligned to latches
   logic           virq_q;                         // virq level, aligned to latches
   logic           dref_q;                         // refresh in progress
   qbus_pkg::irq_t irq_d;                          // encoder output
   qbus_pkg::irq_t irq_q;                          // registered result

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
      begin
         aclo_q <= 1'b0;
         evnt_q <= 1'b0;
         rfrq_q <= 1'b0;
         halt_q <= 1'b0;
         virq_q <= 1'b0;
         dref_q <= 1'b0;
      end
      else
      begin
         if (ctl_i.clr_aclo)
            aclo_q <= 1'b0;                        // clear wins over new edge
         else if (rise_i.aclo)
            aclo_q <= 1'b1;
         if (ctl_i.clr_evnt)
            evnt_q <= 1'b0;
         else if (rise_i.evnt)
            evnt_q <= 1'b1;
         if (rise_i.rfrq)
            rfrq_q <= 1'b1;                        // new request beats set_ref
         else if (ctl_i.set_ref)
            rfrq_q <= 1'b0;
         halt_q <= pins_i.halt;                    // level sources
         virq_q <= pins_i.virq;
         dref_q <= ~ctl_i.clr_ref & (ctl_i.set_ref | dref_q);
      end
   end

   // fixed priority, evnt and virq masked by pri
   always_comb
   begin
      // any unmasked source active
      irq_d.pending = rfrq_q | psw_i.trace | aclo_q | halt_q |
                      ((evnt_q | virq_q) & ~psw_i.pri);
      if (rfrq_q)
         irq_d.vector = qbus_pkg::vec_rfrq;
      else if (psw_i.trace)
         irq_d.vector = qbus_pkg::vec_trace;
      else if (aclo_q)
         irq_d.vector = qbus_pkg::vec_aclo;
      else if (halt_q)
         irq_d.vector = qbus_pkg::vec_halt;
      else if (evnt_q & ~psw_i.pri)
         irq_d.vector = qbus_pkg::vec_evnt;
      else if (virq_q & ~psw_i.pri)
         irq_d.vector = qbus_pkg::vec_virq;
      else
         irq_d.vector = qbus_pkg::vec_none;        // idle
   end

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
         irq_q <= '{pending: 1'b0, vector: qbus_pkg::vec_none};
      else
         irq_q <= irq_d;
   end

   assign irq_o  = irq_q;
   assign dref_o = dref_q;

   // pending and vector must agree in every registered result
   a_pending_vec : assert property (@(posedge pin_clk) disable iff (dclo)
      irq_q.pending == (irq_q.vector != qbus_pkg::vec_none));

endmodule

/* req_sync.sv */
//************************************************************
// Pin group sampler
// registers an asynchronous pin group, flags rising fields
//************************************************************
`timescale 1ns/1ps

module req_sync #(
   parameter type payload_t = logic                // sampled pin group type
)
(
   input  logic     pin_clk,                       // processor clock
   input  logic     dclo,                          // processor reset
   input  payload_t pins_i,                        // raw pin group
   output payload_t sampled_o,                     // pins after one edge
   output payload_t rise_o                         // newly high fields
);

   payload_t smp_q;                                // current sample
   payload_t prev_q;                               // sample one edge older

   always_ff @(posedge pin_clk or posedge dclo)
   begin
      if (dclo)
      begin
         smp_q  <= '0;
         prev_q <= '0;
      end
      else
      begin
         smp_q  <= pins_i;                         // single sampling stage
         prev_q <= smp_q;
      end
   end

   // high now, low at the previous sample
   assign rise_o    = payload_t'(smp_q & ~prev_q);
   assign sampled_o = smp_q;

endmodule

/* qbus_pkg.sv */
//************************************************************
// Q-bus control unit shared definitions
// widths, interrupt vector codes and packed pin/strobe groups
//************************************************************
package qbus_pkg;

   localparam int qt_width  = 6;                   // transaction timer width
   localparam int vec_width = 3;                   // interrupt vector code width

   // vector codes, highest priority first
   localparam logic [vec_width-1:0] vec_rfrq  = 3'd0; // dram refresh request
   localparam logic [vec_width-1:0] vec_trace = 3'd1; // trace trap
   localparam logic [vec_width-1:0] vec_aclo  = 3'd2; // power fail
   localparam logic [vec_width-1:0] vec_halt  = 3'd3; // halt request
   localparam logic [vec_width-1:0] vec_evnt  = 3'd4; // timer event
   localparam logic [vec_width-1:0] vec_virq  = 3'd5; // vectored interrupt
   localparam logic [vec_width-1:0] vec_none  = 3'd7; // nothing pending

   typedef struct packed {
      logic aclo;                                  // power fail notification
      logic evnt;                                  // timer interrupt request
      logic rfrq;                                  // refresh request
      logic halt;                                  // supervisor halt request
      logic virq;                                  // vectored interrupt request
   } irq_pins_t;

   typedef struct packed {
      logic rply;                                  // transaction reply
      logic sack;                                  // dma acknowledge
      logic dmr;                                   // dma bus request
   } bus_pins_t;

   typedef struct packed {
      logic sync;                                  // address strobe
      logic din;                                   // data input strobe
      logic dout;                                  // data output strobe
   } cyc_t;

   typedef struct packed {
      logic clr_aclo;                              // drop power fail latch
      logic clr_evnt;                              // drop timer event latch
      logic set_ref;                               // start refresh, drop rfrq
      logic clr_ref;                               // end refresh
      logic clr_timeout;                           // drop bus timeout flag
   } ctl_t;

   typedef struct packed {
      logic pri;                                   // priority mask, psw bit 7
      logic trace;                                 // trace enable, psw bit 4
   } psw_t;

   typedef struct packed {
      logic                 pending;               // any source active
      logic [vec_width-1:0] vector;                // encoded source
   } irq_t;

endpackage
